// File: common/core_pkg.sv
// widths, instruction encodings, alu operations and the stage payload structs.
package core_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // primary opcode, instr[31:26].
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    HALT  = 6'h3f
  } opcode_t;

  // function field of r-type, instr[5:0].
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_t;

  // decode to execute.
  typedef struct packed {
    alu_op_t              alu_op;
    reg_addr_t            rs;
    reg_addr_t            rt;
    word_t                rs_val;
    word_t                rt_val;
    word_t                imm;
    logic [SHAMT_W-1:0]   shamt;
    logic                 use_imm;
    reg_addr_t            dest;
    logic                 wen;
    logic                 halt;
  } dec_payload_t;

  // execute to result, also what leaves on the retire stream.
  typedef struct packed {
    reg_addr_t dest;
    word_t     value;
    logic      wen;
    logic      halt;
  } exe_payload_t;

  typedef exe_payload_t retire_t;

endpackage

// File: design/decode/register_file.sv
// 32 x 32 register file, r0 hardwired to zero, write-through on read.
`timescale 1ns/10ps

module register_file (
  input  logic                CLK,
  input  logic                nRST,
  input  core_pkg::reg_addr_t rsel1,
  input  core_pkg::reg_addr_t rsel2,
  output core_pkg::word_t     rdat1,
  output core_pkg::word_t     rdat2,
  input  logic                wen,
  input  core_pkg::reg_addr_t wsel,
  input  core_pkg::word_t     wdat
);
  import core_pkg::*;

  word_t regs [2**REG_ADDR_W];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write is seen by the reader.
  assign rdat1 = (rsel1 == '0)                ? '0   :
                 (wen && wsel == rsel1)       ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0)                ? '0   :
                 (wen && wsel == rsel2)       ? wdat : regs[rsel2];

endmodule

// File: design/decode/decode_stage.sv
// decode stage with field split, control decode, immediate extension, regfile reads and halt latch.
`timescale 1ns/10ps

module decode_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  core_pkg::word_t       in_instr,
  output logic                  out_valid,
  input  logic                  out_ready,
  output core_pkg::dec_payload_t out_payload,
  input  logic                  wr_en,
  input  core_pkg::reg_addr_t   wr_addr,
  input  core_pkg::word_t       wr_data
);
  import core_pkg::*;

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs, rt, rd;
  word_t     rdat1, rdat2;
  logic      sign_ext;
  logic      halt_seen;

  assign opcode = opcode_t'(in_instr[31:26]);
  assign funct  = funct_t'(in_instr[5:0]);
  assign rs     = in_instr[25:21];
  assign rt     = in_instr[20:16];
  assign rd     = in_instr[15:11];

  register_file rf (
    .CLK(CLK), .nRST(nRST),
    .rsel1(rs), .rsel2(rt),
    .rdat1(rdat1), .rdat2(rdat2),
    .wen(wr_en), .wsel(wr_addr), .wdat(wr_data)
  );

  // nothing more is taken once a halt has gone in.
  assign out_valid = in_valid & ~halt_seen;
  assign in_ready  = out_ready & ~halt_seen;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt_seen <= 1'b0;
    end else if (in_valid && in_ready && opcode == HALT) begin
      halt_seen <= 1'b1;
    end
  end

  assign sign_ext = (opcode == ADDIU) || (opcode == SLTI);

  always_comb begin
    out_payload         = '0;
    out_payload.rs      = rs;
    out_payload.rt      = rt;
    out_payload.rs_val  = rdat1;
    out_payload.rt_val  = rdat2;
    out_payload.shamt   = in_instr[10:6];
    out_payload.imm     = sign_ext ? {{16{in_instr[15]}}, in_instr[15:0]}
                                   : {16'b0, in_instr[15:0]};
    out_payload.dest    = rt;
    out_payload.use_imm = 1'b1;
    out_payload.wen     = 1'b1;
    case (opcode)
      RTYPE: begin
        out_payload.dest    = rd;
        out_payload.use_imm = 1'b0;
        case (funct)
          SLL:     out_payload.alu_op = ALU_SLL;
          SRL:     out_payload.alu_op = ALU_SRL;
          ADDU:    out_payload.alu_op = ALU_ADD;
          SUBU:    out_payload.alu_op = ALU_SUB;
          AND:     out_payload.alu_op = ALU_AND;
          OR:      out_payload.alu_op = ALU_OR;
          XOR:     out_payload.alu_op = ALU_XOR;
          NOR:     out_payload.alu_op = ALU_NOR;
          SLT:     out_payload.alu_op = ALU_SLT;
          SLTU:    out_payload.alu_op = ALU_SLTU;
          default: out_payload.wen    = 1'b0;
        endcase
      end
      ADDIU:   out_payload.alu_op = ALU_ADD;
      SLTI:    out_payload.alu_op = ALU_SLT;
      ANDI:    out_payload.alu_op = ALU_AND;
      ORI:     out_payload.alu_op = ALU_OR;
      XORI:    out_payload.alu_op = ALU_XOR;
      LUI:     out_payload.alu_op = ALU_LUI;
      HALT: begin
        out_payload.wen  = 1'b0;
        out_payload.halt = 1'b1;
      end
      // unknown opcodes fall through as a no-op.
      default: out_payload.wen = 1'b0;
    endcase
    // r0 is never written.
    if (out_payload.dest == '0) begin
      out_payload.wen = 1'b0;
    end
  end

endmodule

// File: design/stage_reg.sv
// single-entry valid/ready pipeline register for any payload type.
`timescale 1ns/10ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_payload
);

  logic     full;
  payload_t data;

  // accepts when empty or when the entry leaves this cycle.
  assign in_ready    = ~full | out_ready;
  assign out_valid   = full;
  assign out_payload = data;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      data <= '0;
    end else if (in_valid && in_ready) begin
      data <= in_payload;
    end
  end

endmodule

// File: design/execute_stage.sv
// execute stage: operand forwarding from the result entry and the alu.
`timescale 1ns/10ps

module execute_stage (
  input  core_pkg::dec_payload_t in_payload,
  input  logic                   fwd_valid,
  input  core_pkg::reg_addr_t    fwd_dest,
  input  core_pkg::word_t        fwd_value,
  input  logic                   fwd_wen,
  output core_pkg::exe_payload_t out_payload
);
  import core_pkg::*;

  logic  fwd_live;
  word_t rs_fwd, rt_fwd;
  word_t op_a, op_b;
  word_t result;

  // tap only counts for a real write to a non-zero register.
  assign fwd_live = fwd_valid && fwd_wen && (fwd_dest != '0);

  assign rs_fwd = (fwd_live && fwd_dest == in_payload.rs) ? fwd_value : in_payload.rs_val;
  assign rt_fwd = (fwd_live && fwd_dest == in_payload.rt) ? fwd_value : in_payload.rt_val;

  assign op_a = rs_fwd;
  assign op_b = in_payload.use_imm ? in_payload.imm : rt_fwd;

  always_comb begin
    case (in_payload.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_NOR:  result = ~(op_a | op_b);
      ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: result = word_t'(op_a < op_b);
      // shifts act on rt by the shamt field.
      ALU_SLL:  result = op_b << in_payload.shamt;
      ALU_SRL:  result = op_b >> in_payload.shamt;
      ALU_LUI:  result = {in_payload.imm[15:0], 16'b0};
      default:  result = '0;
    endcase
  end

  always_comb begin
    out_payload.dest  = in_payload.dest;
    out_payload.value = result;
    out_payload.wen   = in_payload.wen;
    out_payload.halt  = in_payload.halt;
  end

endmodule

// File: design/result_stage.sv
// result stage: retire stream, register write request and sticky halted flag.
`timescale 1ns/10ps

module result_stage (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  core_pkg::exe_payload_t in_payload,
  output logic                   retire_valid,
  input  logic                   retire_ready,
  output core_pkg::retire_t      retire,
  output logic                   wr_en,
  output core_pkg::reg_addr_t    wr_addr,
  output core_pkg::word_t        wr_data,
  output logic                   halted
);

  logic retire_fire;

  assign retire_valid = in_valid;
  assign in_ready     = retire_ready;
  assign retire       = in_payload;
  assign retire_fire  = in_valid & retire_ready;

  // the register file is written on the retire handshake.
  assign wr_en   = retire_fire & in_payload.wen;
  assign wr_addr = in_payload.dest;
  assign wr_data = in_payload.value;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halted <= 1'b0;
    end else if (retire_fire && in_payload.halt) begin
      halted <= 1'b1;
    end
  end

endmodule

// File: design/pipe_core.sv
// core top: decode, two stage registers, execute and result wired in line.
`timescale 1ns/10ps

module pipe_core (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              in_valid,
  output logic              in_ready,
  input  core_pkg::word_t   in_instr,
  output logic              retire_valid,
  input  logic              retire_ready,
  output core_pkg::retire_t retire,
  output logic              halted
);
  import core_pkg::*;

  logic         dec_valid, dec_ready;
  dec_payload_t dec_payload;
  logic         dx_valid, xr_in_ready;
  dec_payload_t dx_payload;
  exe_payload_t exe_payload;
  logic         xr_valid, xr_ready;
  exe_payload_t xr_payload;
  logic         wr_en;
  reg_addr_t    wr_addr;
  word_t        wr_data;

  decode_stage dec (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
    .out_valid(dec_valid), .out_ready(dec_ready), .out_payload(dec_payload),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  stage_reg #(.payload_t(dec_payload_t)) dx_reg (
    .CLK(CLK), .nRST(nRST),
    .in_valid(dec_valid), .in_ready(dec_ready), .in_payload(dec_payload),
    .out_valid(dx_valid), .out_ready(xr_in_ready), .out_payload(dx_payload)
  );

  // execute is combinational, so its handshake runs straight from dx_reg to xr_reg.
  execute_stage exe (
    .in_payload(dx_payload),
    .fwd_valid(xr_valid), .fwd_dest(xr_payload.dest),
    .fwd_value(xr_payload.value), .fwd_wen(xr_payload.wen),
    .out_payload(exe_payload)
  );

  stage_reg #(.payload_t(exe_payload_t)) xr_reg (
    .CLK(CLK), .nRST(nRST),
    .in_valid(dx_valid), .in_ready(xr_in_ready), .in_payload(exe_payload),
    .out_valid(xr_valid), .out_ready(xr_ready), .out_payload(xr_payload)
  );

  result_stage res (
    .CLK(CLK), .nRST(nRST),
    .in_valid(xr_valid), .in_ready(xr_ready), .in_payload(xr_payload),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .halted(halted)
  );

endmodule

// File: verification/core_checker.sv
// protocol assertions on the core's retire and instruction streams, bound into pipe_core.
`timescale 1ns/10ps

module core_checker (
  input logic              CLK,
  input logic              nRST,
  input logic              in_valid,
  input logic              in_ready,
  input logic              retire_valid,
  input logic              retire_ready,
  input core_pkg::retire_t retire,
  input logic              halted
);

  int fail_count = 0;

  // a stalled retire entry keeps its payload.
  retire_stable: assert property (@(posedge CLK) disable iff (!nRST)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else begin
      $error("retire payload changed while stalled");
      fail_count++;
    end

  // both stage registers come out of reset empty.
  retire_idle_after_reset: assert property (@(posedge CLK)
    $rose(nRST) |-> !retire_valid)
    else begin
      $error("retire_valid high in the first cycle after reset");
      fail_count++;
    end

  halted_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halted |=> halted)
    else begin
      $error("halted fell without a reset");
      fail_count++;
    end

  no_input_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
    halted |-> !(in_valid && in_ready))
    else begin
      $error("instruction accepted after the core halted");
      fail_count++;
    end

endmodule

bind pipe_core core_checker checker_i (
  .CLK(CLK),
  .nRST(nRST),
  .in_valid(in_valid),
  .in_ready(in_ready),
  .retire_valid(retire_valid),
  .retire_ready(retire_ready),
  .retire(retire),
  .halted(halted)
);

// File: verification/core_monitor.sv
// retire monitor with model registers, reference result function and in-order comparison.
`timescale 1ns/10ps

module core_monitor (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              in_valid,
  input  logic              in_ready,
  input  core_pkg::word_t   in_instr,
  input  logic              retire_valid,
  input  logic              retire_ready,
  input  core_pkg::retire_t retire,
  input  logic              halted,
  output int                errors,
  output int                retired
);
  import core_pkg::*;

  word_t   model_regs [32];
  word_t   expected_q [$];
  word_t   cur_instr;
  retire_t exp_retire;
  logic    halt_retired;

  // expected retire entry of one instruction against the model registers.
  function automatic retire_t expected_retire(input word_t instr);
    retire_t r;
    word_t   a;
    word_t   b;
    word_t   simm;
    word_t   zimm;
    a      = model_regs[instr[25:21]];
    b      = model_regs[instr[20:16]];
    simm   = {{16{instr[15]}}, instr[15:0]};
    zimm   = {16'h0, instr[15:0]};
    r      = '0;
    r.dest = instr[20:16];
    r.wen  = 1'b1;
    case (instr[31:26])
      RTYPE: begin
        r.dest = instr[15:11];
        case (instr[5:0])
          ADDU:    r.value = a + b;
          SUBU:    r.value = a - b;
          AND:     r.value = a & b;
          OR:      r.value = a | b;
          XOR:     r.value = a ^ b;
          NOR:     r.value = ~(a | b);
          SLT:     r.value = {31'h0, $signed(a) < $signed(b)};
          SLTU:    r.value = {31'h0, a < b};
          SLL:     r.value = b << instr[10:6];
          SRL:     r.value = b >> instr[10:6];
          default: r.wen = 1'b0;
        endcase
      end
      ADDIU:   r.value = a + simm;
      SLTI:    r.value = {31'h0, $signed(a) < $signed(simm)};
      ANDI:    r.value = a & zimm;
      ORI:     r.value = a | zimm;
      XORI:    r.value = a ^ zimm;
      LUI:     r.value = {instr[15:0], 16'h0};
      HALT: begin
        r.wen  = 1'b0;
        r.halt = 1'b1;
      end
      default: r.wen = 1'b0;
    endcase
    if (r.dest == '0) begin
      r.wen = 1'b0;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      errors       = 0;
      retired      = 0;
      halt_retired = 1'b0;
      expected_q.delete();
      foreach (model_regs[i]) begin
        model_regs[i] = '0;
      end
    end else begin
      // halted rises on the edge where the halt retires.
      check_field("halted", word_t'(halted), word_t'(halt_retired));
      if (retire_valid && retire_ready) begin
        if (halted) begin
          $display("retirement seen at %0t after the core halted", $time);
          errors++;
        end
        if (expected_q.size() == 0) begin
          $display("retirement at %0t with no instruction outstanding", $time);
          errors++;
        end else begin
          cur_instr  = expected_q.pop_front();
          exp_retire = expected_retire(cur_instr);
          check_field("retire.wen", word_t'(retire.wen), word_t'(exp_retire.wen));
          check_field("retire.halt", word_t'(retire.halt), word_t'(exp_retire.halt));
          // dest and value only mean something for a real write.
          if (exp_retire.wen) begin
            check_field("retire.dest", word_t'(retire.dest), word_t'(exp_retire.dest));
            check_field("retire.value", retire.value, exp_retire.value);
            model_regs[exp_retire.dest] = exp_retire.value;
          end
          if (exp_retire.halt) begin
            halt_retired = 1'b1;
          end
          retired++;
        end
      end
      if (in_valid && in_ready) begin
        expected_q.push_back(in_instr);
      end
      if (halted && in_ready) begin
        $display("in_ready high at %0t after the core halted", $time);
        errors++;
      end
    end
  end

endmodule

// File: verification/core_tb.sv
// testbench top with clock, reset, program stimulus, retire back-pressure, watchdog and report.
`timescale 1ns/10ps

module core_tb;
  import core_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int PROG_LEN   = 60;
  localparam int TIMEOUT_NS = PROG_LEN * 20 * CLK_PERIOD;

  logic    CLK;
  logic    nRST;
  logic    in_valid;
  logic    in_ready;
  word_t   in_instr;
  logic    retire_valid;
  logic    retire_ready;
  retire_t retire;
  logic    halted;
  int      mon_errors;
  int      retired;
  int      tb_errors;
  int      total_errors;
  integer  seed;
  word_t   prog [PROG_LEN];

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  pipe_core pipe_core_i (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire),
    .halted(halted)
  );

  core_monitor monitor_i (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire),
    .halted(halted), .errors(mon_errors), .retired(retired)
  );

  // directed corner cases, then every operation in turn with distance one and two chains.
  task automatic build_program();
    word_t      ops [16];
    word_t      rnd;
    logic [4:0] d;
    logic [4:0] rs;
    logic [4:0] rt;
    ops = '{{26'h0, ADDU}, {26'h0, SUBU}, {26'h0, AND}, {26'h0, OR},
            {26'h0, XOR}, {26'h0, NOR}, {26'h0, SLT}, {26'h0, SLTU},
            {26'h0, SLL}, {26'h0, SRL}, {ADDIU, 26'h0}, {SLTI, 26'h0},
            {ANDI, 26'h0}, {ORI, 26'h0}, {XORI, 26'h0}, {LUI, 26'h0}};
    prog[0] = {LUI, 5'd0, 5'd1, 16'h8001};
    prog[1] = {ORI, 5'd1, 5'd1, 16'hf00f};
    prog[2] = {ADDIU, 5'd0, 5'd2, 16'hfff0};
    prog[3] = {SLTI, 5'd2, 5'd3, 16'h0005};
    prog[4] = {ADDIU, 5'd1, 5'd0, 16'h0007};
    prog[5] = {RTYPE, 5'd0, 5'd1, 5'd4, 5'd0, ADDU};
    prog[6] = {6'h2b, 5'd1, 5'd5, 16'h0000};
    prog[7] = {RTYPE, 5'd1, 5'd2, 5'd6, 5'd0, 6'h08};
    for (int i = 8; i < PROG_LEN - 1; i++) begin
      rnd = $random(seed);
      d   = 5'(1 + i % 9);
      rs  = 5'(1 + (i - 1) % 9);
      rt  = 5'(1 + (i - 2) % 9);
      if (ops[(i - 8) % 16][31:26] == RTYPE) begin
        prog[i] = ops[(i - 8) % 16] | {6'h0, rs, rt, d, rnd[10:6], 6'h0};
      end else begin
        prog[i] = ops[(i - 8) % 16] | {6'h0, rs, d, rnd[15:0]};
      end
    end
    prog[PROG_LEN - 1] = {HALT, 26'h0};
  endtask

  task automatic send(input word_t instr);
    in_valid <= 1'b1;
    in_instr <= instr;
    @(posedge CLK);
    while (!in_ready) begin
      @(posedge CLK);
    end
  endtask

  // roughly three cycles in four ready.
  always @(posedge CLK) begin
    if (nRST) begin
      retire_ready <= ($random(seed) & 32'sd3) != 0;
    end
  end

  initial begin
    nRST         = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    retire_ready = 1'b0;
    tb_errors    = 0;
    seed         = 32'he45a_336a;
    build_program();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    for (int i = 0; i < PROG_LEN; i++) begin
      send(prog[i]);
    end
    // keep offering one more instruction behind the halt.
    in_instr <= {ADDIU, 5'd0, 5'd9, 16'h0001};
    while (!halted) begin
      @(posedge CLK);
    end
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    if (retired != PROG_LEN) begin
      $display("wrong retirement count: expected %0d, saw %0d", PROG_LEN, retired);
      tb_errors++;
    end
    total_errors = mon_errors + pipe_core_i.checker_i.fail_count + tb_errors;
    $display("errors: %0d total, monitor %0d, checker %0d, testbench %0d", total_errors,
             mon_errors, pipe_core_i.checker_i.fail_count, tb_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the core did not halt within %0d ns", TIMEOUT_NS);
    $display("errors: monitor %0d, checker %0d, testbench %0d, timeout 1", mon_errors,
             pipe_core_i.checker_i.fail_count, tb_errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: files.f
common/core_pkg.sv
design/decode/register_file.sv
design/decode/decode_stage.sv
design/stage_reg.sv
design/execute_stage.sv
design/result_stage.sv
design/pipe_core.sv
verification/core_checker.sv
verification/core_monitor.sv
verification/core_tb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench.
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
